// File: sim.f
+incdir+dv
logic/cholesky_pkg.sv
logic/cholesky_regs.sv
logic/cholesky_ctrl.sv
logic/array_mult.sv
logic/array_div.sv
logic/sqrt_unit.sv
logic/cholesky.sv
dv/cholesky_tb.sv

// File: Bender.yml
package:
  name: cholesky

sources:
  - logic/cholesky_pkg.sv
  - logic/cholesky_regs.sv
  - logic/cholesky_ctrl.sv
  - logic/array_mult.sv
  - logic/array_div.sv
  - logic/sqrt_unit.sv
  - logic/cholesky.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/cholesky_tb.sv

// File: dv/cholesky_ref.svh
/* Q8.8 Cholesky reference and SPD generator for 4x4 matrices. Works on the testbench
   arrays a_mat and l_exp, and draws from the seed variable in scope. */
`ifndef CHOLESKY_REF_SVH
`define CHOLESKY_REF_SVH

// Q8.8 product, floored back to 16 bits.
function automatic fix_t fix_mul(input fix_t x, input fix_t y);
	longint prod;
	prod = longint'(x) * longint'(y);
	return fix_t'(prod >>> 8);
endfunction

function automatic longint isqrt(input longint v);
	longint r;
	r = 0;
	for (int b = 23; b >= 0; b--) begin
		if ((r + (longint'(1) << b)) * (r + (longint'(1) << b)) <= v)
			r = r + (longint'(1) << b);
	end
	return r;
endfunction

// Fills l_exp from a_mat; returns 1 and stops at the first radicand that is not positive.
function automatic logic cholesky_ref();
	acc_t   acc;
	longint q;
	for (int r = 0; r < 4; r++)
		for (int c = 0; c < 4; c++)
			l_exp[r][c] = '0;
	for (int j = 0; j < 4; j++) begin
		acc = acc_t'(a_mat[j][j]);
		for (int k = 0; k < j; k++)
			acc = acc - acc_t'(fix_mul(l_exp[j][k], l_exp[j][k]));
		if (acc <= 0)
			return 1'b1;
		l_exp[j][j] = fix_t'(isqrt(longint'(acc) << 8));
		for (int i = j + 1; i < 4; i++) begin
			acc = acc_t'(a_mat[i][j]);
			for (int k = 0; k < j; k++)
				acc = acc - acc_t'(fix_mul(l_exp[i][k], l_exp[j][k]));
			q = (longint'(acc) * 256) / longint'(l_exp[j][j]);   // Truncates toward zero.
			l_exp[i][j] = fix_t'(q);
		end
	end
	return 1'b0;
endfunction

// A = B*B' + 2I, B entries within about +-1.5.
function automatic void make_spd();
	fix_t b [4][4];
	acc_t sum;
	for (int r = 0; r < 4; r++)
		for (int c = 0; c < 4; c++)
			b[r][c] = fix_t'($random(seed) % 384);
	for (int r = 0; r < 4; r++)
		for (int c = 0; c < 4; c++) begin
			sum = 0;
			for (int k = 0; k < 4; k++)
				sum = sum + acc_t'(fix_mul(b[r][k], b[c][k]));
			a_mat[r][c] = fix_t'(sum + ((r == c) ? 512 : 0));
		end
endfunction

`endif

// File: dv/cholesky_tb.sv
/* Testbench for the Cholesky core with N = 4 over AXI4-Lite. Matrices stay small so
   nothing overflows Q8.8; a cycle watchdog bounds the run. */
`timescale 1ns/1ps

module cholesky_tb
	import cholesky_pkg::*;
();

	localparam int  NUM_TESTS = 15;
	localparam time CLK_NS    = 100;

	logic        ifc_cholesky;
	logic        reset;
	logic [7:0]  awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [7:0]  araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;
	logic        done;

	fix_t   a_mat [4][4];
	fix_t   l_exp [4][4];
	integer seed = 15;
	int     checks;
	int     value_errors;
	int     other_errors;

	`include "cholesky_ref.svh"

	cholesky UUT (.*);

	initial begin
		ifc_cholesky = 1'b0;
		forever #(CLK_NS / 2) ifc_cholesky = ~ifc_cholesky;
	end

	initial begin
		#(NUM_TESTS * 2000 * CLK_NS);
		$display("Watchdog expired after %0d cycles, the run did not finish", NUM_TESTS * 2000);
		$display("Done: errors found");
		$finish;
	end

	task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			value_errors++;
			$display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		@(posedge ifc_cholesky);
		#1;
		awaddr  = addr;
		wdata   = data;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		bready  = 1'b1;
		@(negedge ifc_cholesky);
		while (!awready)
			@(negedge ifc_cholesky);
		if (wready !== 1'b1) begin
			other_errors++;
			$display("wready did not rise together with awready, at %0t", $time);
		end
		@(posedge ifc_cholesky);
		#1;
		awvalid = 1'b0;
		wvalid  = 1'b0;
		@(negedge ifc_cholesky);
		while (!bvalid)
			@(negedge ifc_cholesky);
		resp = bresp;
		@(posedge ifc_cholesky);
		#1;
		bready = 1'b0;
	endtask

	// Holds rready low for hold cycles once rvalid is up.
	task automatic axi_read(input logic [7:0] addr, input int hold,
			output logic [31:0] data, output logic [1:0] resp);
		@(posedge ifc_cholesky);
		#1;
		araddr  = addr;
		arvalid = 1'b1;
		rready  = (hold == 0);
		@(negedge ifc_cholesky);
		while (!arready)
			@(negedge ifc_cholesky);
		@(posedge ifc_cholesky);
		#1;
		arvalid = 1'b0;
		@(negedge ifc_cholesky);
		while (!rvalid)
			@(negedge ifc_cholesky);
		data = rdata;
		resp = rresp;
		for (int c = 0; c < hold; c++) begin
			@(negedge ifc_cholesky);
			if (!rvalid || rdata !== data) begin
				other_errors++;
				$display("Read data did not hold while rready was low, at %0t", $time);
			end
		end
		if (hold > 0) begin
			@(posedge ifc_cholesky);
			#1;
			rready = 1'b1;
		end
		@(posedge ifc_cholesky);
		#1;
		rready = 1'b0;
	endtask

	function automatic void set_diag(input fix_t val);
		for (int r = 0; r < 4; r++)
			for (int c = 0; c < 4; c++)
				a_mat[r][c] = (r == c) ? val : fix_t'(0);
	endfunction

	task automatic load_matrix();
		logic [1:0] resp;
		for (int r = 0; r < 4; r++)
			for (int c = 0; c <= r; c++) begin
				axi_write(ADDR_A_BASE + 8'((r * 4 + c) * 4), 32'(a_mat[r][c]), resp);
				check_word("A write response", 32'(resp), 32'd0);
			end
	endtask

	task automatic start_run();
		logic [1:0] resp;
		axi_write(ADDR_CTRL, 32'd1, resp);
	endtask

	task automatic wait_done(output logic [31:0] status);
		logic [1:0] resp;
		int         polls;
		polls  = 0;
		status = '0;
		while (!status[1] && polls < 400) begin   // Bit 1 is done.
			axi_read(ADDR_STATUS, 0, status, resp);
			polls++;
		end
		if (!status[1]) begin
			other_errors++;
			$display("Status never reported done after %0d polls", polls);
		end
	endtask

	// Waits for done, then compares status and all 16 L words with l_exp.
	task automatic check_result(input string tag, input logic exp_npd);
		logic [31:0] status;
		logic [31:0] word;
		logic [1:0]  resp;
		wait_done(status);
		check_word({tag, " status"}, status, {29'd0, exp_npd, 2'b10});
		check_word({tag, " done port"}, 32'(done), 32'd1);
		for (int r = 0; r < 4; r++)
			for (int c = 0; c < 4; c++) begin
				axi_read(ADDR_L_BASE + 8'((r * 4 + c) * 4), 0, word, resp);
				check_word($sformatf("%s L[%0d][%0d]", tag, r, c), word, 32'(l_exp[r][c]));
				if (resp !== 2'b00) begin
					other_errors++;
					$display("L read in %s answered with an error response", tag);
				end
			end
	endtask

	initial begin
		logic [31:0] word;
		logic [1:0]  resp;
		reset        = 1'b1;
		awaddr       = '0;
		awvalid      = 1'b0;
		wdata        = '0;
		wvalid       = 1'b0;
		bready       = 1'b0;
		araddr       = '0;
		arvalid      = 1'b0;
		rready       = 1'b0;
		checks       = 0;
		value_errors = 0;
		other_errors = 0;
		repeat (8) @(posedge ifc_cholesky);
		#1;
		reset = 1'b0;

		// Register map, error responses and sign extension.
		axi_read(8'h08, 0, word, resp);
		check_word("unmapped read response", 32'(resp), 32'd2);
		check_word("unmapped read data", word, 32'd0);
		axi_write(ADDR_L_BASE, 32'h0000_1234, resp);
		check_word("L write response", 32'(resp), 32'd2);
		axi_read(ADDR_L_BASE, 0, word, resp);
		check_word("L[0][0] after L write", word, 32'd0);
		axi_write(ADDR_A_BASE + 8'h3C, 32'h0000_FF80, resp);
		axi_read(ADDR_A_BASE + 8'h3C, 0, word, resp);
		check_word("A[3][3] readback", word, 32'hFFFF_FF80);

		// 4I factors to 2I.
		set_diag(16'h0400);
		load_matrix();
		for (int r = 0; r < 4; r++)
			for (int c = 0; c < 4; c++)
				l_exp[r][c] = (r == c) ? 16'h0200 : 16'h0000;
		start_run();
		check_result("identity", 1'b0);

		for (int t = 0; t < 10; t++) begin
			make_spd();
			load_matrix();
			void'(cholesky_ref());
			start_run();
			check_result($sformatf("random %0d", t), 1'b0);
		end

		axi_read(ADDR_L_BASE + 8'h10, 5, word, resp);
		check_word("held read of L[1][0]", word, 32'(l_exp[1][0]));

		// Restart clears done and the old L before the new result lands.
		make_spd();
		load_matrix();
		void'(cholesky_ref());
		start_run();
		axi_read(ADDR_STATUS, 0, word, resp);
		check_word("status after restart", word, 32'd1);
		check_word("done port after restart", 32'(done), 32'd0);
		axi_read(ADDR_L_BASE + 8'h3C, 0, word, resp);
		check_word("L[3][3] after restart", word, 32'd0);
		axi_read(ADDR_L_BASE + 8'h38, 0, word, resp);
		check_word("L[3][2] after restart", word, 32'd0);
		check_result("restart", 1'b0);

		// Column 1 radicand goes negative.
		set_diag(16'h0400);
		a_mat[1][1] = 16'hFF80;
		a_mat[1][0] = 16'h0100;
		a_mat[2][0] = 16'h0080;
		a_mat[3][1] = 16'h0100;
		load_matrix();
		void'(cholesky_ref());
		start_run();
		check_result("not positive definite", 1'b1);

		$display("Checks: %0d, value errors: %0d, other errors: %0d",
			checks, value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// File: logic/cholesky.sv
/* Cholesky core top. N from 2 to 4; latency varies, watch the done output or status bit. */
`timescale 1ns/1ps

module cholesky
	import cholesky_pkg::*;
#(
	parameter int N        = 4,
	parameter int DIV_BITS = 24
) (
	input  logic        ifc_cholesky,
	input  logic        reset,
	input  logic [7:0]  awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,
	input  logic [7:0]  araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready,
	output logic        done
);

	logic        start;
	mat_rd_t     mat_rd;
	mat_rd_t     l_rd;
	fix_t        a_data;
	fix_t        l_data;
	l_wr_t       l_wr;
	run_status_t run_status;
	logic        mult_in_valid;
	logic        mult_out_valid;
	fix_t        mult_a;
	fix_t        mult_b;
	fix_t        mult_p;
	logic        div_start;
	logic        div_done;
	acc_t        div_num;
	fix_t        div_den;
	fix_t        div_q;
	logic        sqrt_start;
	logic        sqrt_done;
	acc_t        sqrt_rad;
	fix_t        sqrt_root;

	assign done = run_status.done;

	cholesky_regs u_regs (
		.ifc_cholesky, .reset,
		.awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
		.start, .mat_rd, .l_rd, .a_data, .l_data, .l_wr, .run_status
	);

	cholesky_ctrl #(.N(N)) u_ctrl (
		.ifc_cholesky, .reset, .start,
		.mat_rd, .l_rd, .a_data, .l_data, .l_wr, .run_status,
		.mult_in_valid, .mult_a, .mult_b, .mult_out_valid, .mult_p,
		.div_start, .div_num, .div_den, .div_done, .div_q,
		.sqrt_start, .sqrt_rad, .sqrt_done, .sqrt_root
	);

	array_mult u_mult (
		.ifc_cholesky, .reset,
		.in_valid(mult_in_valid), .a(mult_a), .b(mult_b),
		.out_valid(mult_out_valid), .p(mult_p)
	);

	array_div #(.DIV_BITS(DIV_BITS)) u_div (
		.ifc_cholesky, .reset,
		.start(div_start), .num(div_num), .den(div_den),
		.done(div_done), .q(div_q)
	);

	sqrt_unit u_sqrt (
		.ifc_cholesky, .reset,
		.start(sqrt_start), .rad(sqrt_rad),
		.done(sqrt_done), .root(sqrt_root)
	);

endmodule

// File: logic/sqrt_unit.sv
/* Floor square root of rad shifted left 8, two radicand bits per cycle. rad must be
   positive; only the low 16 bits of the root are returned. */
`timescale 1ns/1ps

module sqrt_unit
	import cholesky_pkg::*;
(
	input  logic ifc_cholesky,
	input  logic reset,
	input  logic start,
	input  acc_t rad,
	output logic done,
	output fix_t root
);

	localparam int STEPS = (32 + FRAC) / 2;
	localparam int CNT_W = $clog2(STEPS + 1);

	logic [2*STEPS-1:0] x;             // Radicand, consumed from the top.
	logic [STEPS-1:0]   r;             // Partial root.
	logic [STEPS+1:0]   rem;
	logic [STEPS+3:0]   rem_sh;
	logic [STEPS+3:0]   trial;
	logic [CNT_W-1:0]   cnt;
	logic               run;
	logic               fits;

	assign rem_sh = {rem, x[2*STEPS-1 -: 2]};
	assign trial  = {2'b00, r, 2'b01};         // 4r + 1.
	assign fits   = rem_sh >= trial;

	always_ff @(posedge ifc_cholesky) begin
		if (reset) begin
			run  <= 1'b0;
			done <= 1'b0;
			cnt  <= '0;
		end else begin
			done <= 1'b0;
			if (start && !run) begin
				run <= 1'b1;
				cnt <= CNT_W'(STEPS);
			end else if (run) begin
				cnt <= cnt - 1'b1;
				if (cnt == 1) begin
					run  <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge ifc_cholesky) begin
		if (start && !run) begin
			x   <= {rad, {FRAC{1'b0}}};
			r   <= '0;
			rem <= '0;
		end else if (run) begin
			x   <= x << 2;
			rem <= fits ? (STEPS+2)'(rem_sh - trial) : (STEPS+2)'(rem_sh);
			r   <= {r[STEPS-2:0], fits};
			if (cnt == 1)
				root <= fix_t'({r[14:0], fits});    // Last digit goes straight out.
		end
	end

endmodule

// File: logic/array_div.sv
/* Restoring divider, one quotient bit per cycle. num shifted left 8 must fit in DIV_BITS
   bits; den must be nonzero. Quotient truncates toward zero and keeps the low 16 bits. */
`timescale 1ns/1ps

module array_div
	import cholesky_pkg::*;
#(
	parameter int DIV_BITS = 24
) (
	input  logic ifc_cholesky,
	input  logic reset,
	input  logic start,
	input  acc_t num,
	input  fix_t den,
	output logic done,
	output fix_t q
);

	localparam int CNT_W = $clog2(DIV_BITS + 1);

	logic [DIV_BITS-1:0] quo;          // Dividend shifting out, quotient shifting in.
	logic [15:0]         rem;
	logic [15:0]         dmag;
	logic [16:0]         rem_sh;
	logic [CNT_W-1:0]    cnt;
	acc_t                num_mag;
	logic                neg;
	logic                run;
	logic                fix;
	logic                take;
	logic                fits;

	assign take    = start && !run && !fix;
	assign num_mag = num[31] ? -num : num;
	assign rem_sh  = {rem, quo[DIV_BITS-1]};
	assign fits    = rem_sh >= {1'b0, dmag};

	always_ff @(posedge ifc_cholesky) begin
		if (reset) begin
			run  <= 1'b0;
			fix  <= 1'b0;
			done <= 1'b0;
			cnt  <= '0;
		end else begin
			done <= fix;
			fix  <= run && (cnt == 1);
			if (take) begin
				run <= 1'b1;
				cnt <= CNT_W'(DIV_BITS);
			end else if (run) begin
				cnt <= cnt - 1'b1;
				if (cnt == 1)
					run <= 1'b0;
			end
		end
	end

	always_ff @(posedge ifc_cholesky) begin
		if (take) begin
			quo  <= DIV_BITS'(num_mag << FRAC);
			rem  <= '0;
			dmag <= den[15] ? -den : den;
			neg  <= num[31] ^ den[15];
		end else if (run) begin
			rem <= fits ? 16'(rem_sh - {1'b0, dmag}) : rem_sh[15:0];
			quo <= {quo[DIV_BITS-2:0], fits};
		end
		if (fix)
			q <= neg ? -fix_t'(quo) : fix_t'(quo);   // Sign fix-up.
	end

endmodule

// File: logic/array_mult.sv
/* Two-stage Q8.8 multiplier, one product per cycle. Result is floored and wraps on overflow. */
`timescale 1ns/1ps

module array_mult
	import cholesky_pkg::*;
(
	input  logic ifc_cholesky,
	input  logic reset,
	input  logic in_valid,
	input  fix_t a,
	input  fix_t b,
	output logic out_valid,
	output fix_t p
);

	acc_t prod;
	logic prod_valid;

	always_ff @(posedge ifc_cholesky) begin
		if (reset) begin
			prod_valid <= 1'b0;
			out_valid  <= 1'b0;
		end else begin
			prod_valid <= in_valid;
			out_valid  <= prod_valid;
		end
	end

	always_ff @(posedge ifc_cholesky) begin
		if (in_valid)
			prod <= a * b;                         // Full Q16.16 product.
		if (prod_valid)
			p <= fix_t'(prod >>> FRAC);            // Floor back to Q8.8.
	end

endmodule

// File: logic/cholesky_ctrl.sv
/* Column sequencer. Starts are only taken in idle; the divider and root unit are
   single-issue, so each run waits for its done pulse before moving on. */
`timescale 1ns/1ps

module cholesky_ctrl
	import cholesky_pkg::*;
#(
	parameter int N = 4
) (
	input  logic        ifc_cholesky,
	input  logic        reset,
	input  logic        start,
	output mat_rd_t     mat_rd,
	output mat_rd_t     l_rd,
	input  fix_t        a_data,
	input  fix_t        l_data,
	output l_wr_t       l_wr,
	output run_status_t run_status,
	output logic        mult_in_valid,
	output fix_t        mult_a,
	output fix_t        mult_b,
	input  logic        mult_out_valid,
	input  fix_t        mult_p,
	output logic        div_start,
	output acc_t        div_num,
	output fix_t        div_den,
	input  logic        div_done,
	input  fix_t        div_q,
	output logic        sqrt_start,
	output acc_t        sqrt_rad,
	input  logic        sqrt_done,
	input  fix_t        sqrt_root
);

	localparam idx_t LAST = idx_t'(N - 1);

	ctrl_state_t state;
	idx_t        j;                  // Current column.
	idx_t        i;                  // Current row, equal to j on the diagonal.
	idx_t        iss;                // Products issued.
	idx_t        ret;                // Products returned.
	acc_t        acc;
	fix_t        lj [N];             // Row j of L, cached for the off-diagonal terms.
	logic        in_mult;
	logic        terms_done;

	assign in_mult    = (state == mult_diag) || (state == mult_off);
	assign terms_done = (ret == j);

	assign mat_rd = '{row: i, col: j};
	assign l_rd   = '{row: i, col: iss};

	assign mult_in_valid = in_mult && (iss != j);
	assign mult_a        = l_data;
	assign mult_b        = (state == mult_diag) ? l_data : lj[iss];

	assign sqrt_start = (state == mult_diag) && terms_done && (acc > 0);
	assign sqrt_rad   = acc;
	assign div_start  = (state == mult_off) && terms_done;
	assign div_num    = acc;
	assign div_den    = lj[j];

	// Roots land on the diagonal, quotients below it.
	assign l_wr.valid = ((state == root) && sqrt_done) || ((state == divide) && div_done);
	assign l_wr.row   = i;
	assign l_wr.col   = j;
	assign l_wr.value = (state == root) ? sqrt_root : div_q;

	always_ff @(posedge ifc_cholesky) begin
		if (reset) begin
			state      <= idle;
			j          <= '0;
			i          <= '0;
			iss        <= '0;
			ret        <= '0;
			run_status <= '0;
		end else begin
			case (state)
				idle: begin
					if (start) begin
						j          <= '0;
						i          <= '0;
						run_status <= '{not_pd: 1'b0, done: 1'b0, busy: 1'b1};
						state      <= load_diag;
					end
				end
				load_diag, load_off: begin
					iss   <= '0;
					ret   <= '0;
					state <= (state == load_diag) ? mult_diag : mult_off;
				end
				mult_diag, mult_off: begin
					if (mult_in_valid)
						iss <= iss + 1'b1;
					if (mult_out_valid)
						ret <= ret + 1'b1;
					if (terms_done) begin
						if (state == mult_off) begin
							state <= divide;
						end else if (acc > 0) begin
							state <= root;
						end else begin
							run_status.not_pd <= 1'b1;   // Radicand not positive.
							state             <= finish;
						end
					end
				end
				root: begin
					if (sqrt_done) begin
						if (j == LAST) begin
							state <= finish;
						end else begin
							i     <= j + 1'b1;
							state <= load_off;
						end
					end
				end
				divide: begin
					if (div_done) begin
						if (i == LAST) begin
							j     <= j + 1'b1;
							i     <= j + 1'b1;
							state <= load_diag;
						end else begin
							i     <= i + 1'b1;
							state <= load_off;
						end
					end
				end
				finish: begin
					run_status.busy <= 1'b0;
					run_status.done <= 1'b1;
					state           <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge ifc_cholesky) begin
		if ((state == load_diag) || (state == load_off))
			acc <= acc_t'(a_data);                 // Sign-extend A[i][j].
		else if (mult_out_valid)
			acc <= acc - acc_t'(mult_p);
		if ((state == mult_diag) && mult_in_valid)
			lj[iss] <= l_data;
		if ((state == root) && sqrt_done)
			lj[j] <= sqrt_root;
	end

	a_div_single: assert property (@(posedge ifc_cholesky) disable iff (reset)
		div_start |=> (!div_start throughout div_done [->1]));

	a_sqrt_single: assert property (@(posedge ifc_cholesky) disable iff (reset)
		sqrt_start |=> (!sqrt_start throughout sqrt_done [->1]));

endmodule

// File: logic/cholesky_regs.sv
/* AXI4-Lite register file. Strobes are ignored; L and status are read-only and writes
   to them, or to unmapped offsets, answer SLVERR. A writes while busy are dropped. */
`timescale 1ns/1ps

module cholesky_regs
	import cholesky_pkg::*;
(
	input  logic        ifc_cholesky,
	input  logic        reset,
	input  logic [7:0]  awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,
	input  logic [7:0]  araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready,
	output logic        start,
	input  mat_rd_t     mat_rd,
	input  mat_rd_t     l_rd,
	output fix_t        a_data,
	output fix_t        l_data,
	input  l_wr_t       l_wr,
	input  run_status_t run_status
);

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	fix_t        a_mem [16];
	fix_t        l_mem [16];
	logic        wr_go;
	logic        rd_go;
	logic        wr_is_ctrl;
	logic        wr_is_a;
	logic        rd_err;
	logic [31:0] rd_word;

	assign wr_go      = awvalid && wvalid && !bvalid;
	assign awready    = wr_go;
	assign wready     = wr_go;
	assign wr_is_ctrl = (awaddr == ADDR_CTRL);
	assign wr_is_a    = (awaddr[7:6] == ADDR_A_BASE[7:6]);

	assign rd_go   = arvalid && !rvalid;
	assign arready = rd_go;

	// Controller side, combinational read ports.
	assign a_data = a_mem[{mat_rd.row, mat_rd.col}];
	assign l_data = l_mem[{l_rd.row, l_rd.col}];

	always_ff @(posedge ifc_cholesky) begin
		if (reset) begin
			bvalid <= 1'b0;
			start  <= 1'b0;
		end else begin
			start <= wr_go && wr_is_ctrl && wdata[0] && !run_status.busy;
			if (wr_go)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	always_ff @(posedge ifc_cholesky) begin
		if (wr_go)
			bresp <= (wr_is_ctrl || wr_is_a) ? RESP_OKAY : RESP_SLVERR;
		if (wr_go && wr_is_a && !run_status.busy)
			a_mem[awaddr[5:2]] <= fix_t'(wdata[15:0]);   // Upper bits dropped.
	end

	// L is wiped at the start of every run so a failed run leaves zeros behind.
	always_ff @(posedge ifc_cholesky) begin
		if (reset || start) begin
			for (int k = 0; k < 16; k++)
				l_mem[k] <= '0;
		end else if (l_wr.valid) begin
			l_mem[{l_wr.row, l_wr.col}] <= l_wr.value;
		end
	end

	always_comb begin
		rd_word = '0;
		rd_err  = 1'b0;
		if (araddr == ADDR_STATUS)
			rd_word = 32'(run_status);
		else if (araddr[7:6] == ADDR_A_BASE[7:6])
			rd_word = {{16{a_mem[araddr[5:2]][15]}}, a_mem[araddr[5:2]]};
		else if (araddr[7:6] == ADDR_L_BASE[7:6])
			rd_word = {{16{l_mem[araddr[5:2]][15]}}, l_mem[araddr[5:2]]};
		else if (araddr != ADDR_CTRL)
			rd_err = 1'b1;                                  // Unmapped.
	end

	always_ff @(posedge ifc_cholesky) begin
		if (reset)
			rvalid <= 1'b0;
		else if (rd_go)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

	always_ff @(posedge ifc_cholesky) begin
		if (rd_go) begin
			rdata <= rd_word;
			rresp <= rd_err ? RESP_SLVERR : RESP_OKAY;
		end
	end

	a_bvalid_hold: assert property (@(posedge ifc_cholesky) disable iff (reset)
		bvalid && !bready |=> bvalid && $stable(bresp));

endmodule

// File: logic/cholesky_pkg.sv
/* Shared types for the Q8.8 Cholesky core. Indices are 2 bits, so matrices are at most 4x4.
   Register map is byte addressed with A and L stored row-major, 4 words per row. */
package cholesky_pkg;

	localparam int FRAC = 8;                       // Fraction bits of Q8.8.

	typedef logic signed [15:0] fix_t;             // Q8.8 matrix entry.
	typedef logic signed [31:0] acc_t;             // Dot-product sum or radicand.
	typedef logic [1:0] idx_t;                     // Row or column index.

	typedef enum logic [2:0] {
		idle,
		load_diag,
		mult_diag,
		root,
		load_off,
		mult_off,
		divide,
		finish
	} ctrl_state_t;

	typedef struct packed {
		idx_t row;
		idx_t col;
	} mat_rd_t;

	typedef struct packed {
		logic valid;
		idx_t row;
		idx_t col;
		fix_t value;
	} l_wr_t;

	// Status register layout, busy in bit 0.
	typedef struct packed {
		logic not_pd;
		logic done;
		logic busy;
	} run_status_t;

	localparam logic [7:0] ADDR_CTRL   = 8'h00;
	localparam logic [7:0] ADDR_STATUS = 8'h04;
	localparam logic [7:0] ADDR_A_BASE = 8'h40;
	localparam logic [7:0] ADDR_L_BASE = 8'h80;

endpackage
